// File: rtl/apf_bridge_pkg.sv
// host bridge address map, region codes and option register offsets
// shared by the decode and register bank logic
package apf_bridge_pkg;

	localparam int bridge_addr_w = 32;
	localparam int bridge_data_w = 32;

	// address top byte of each bridge window
	localparam logic [7:0] region_rom_p = 8'h10;
	localparam logic [7:0] region_rom_v = 8'h20;
	localparam logic [7:0] region_cfg   = 8'hF0;

	// option bank offset, taken from address bits 7:0
	localparam int cfg_offset_w = 8;

	localparam logic [cfg_offset_w-1:0] cfg_off_map_1       = 8'h00;
	localparam logic [cfg_offset_w-1:0] cfg_off_map_2       = 8'h04;
	localparam logic [cfg_offset_w-1:0] cfg_off_dipsw       = 8'h08;
	localparam logic [cfg_offset_w-1:0] cfg_off_system_type = 8'h0C;
	localparam logic [cfg_offset_w-1:0] cfg_off_memcard     = 8'h10;
	localparam logic [cfg_offset_w-1:0] cfg_off_video_mode  = 8'h18;
	localparam logic [cfg_offset_w-1:0] cfg_off_ch_enable   = 8'h1C;
	localparam logic [cfg_offset_w-1:0] cfg_off_snd_enable  = 8'h20;
	localparam logic [cfg_offset_w-1:0] cfg_off_pchip_main  = 8'h24;
	localparam logic [cfg_offset_w-1:0] cfg_off_use_pcm     = 8'h28;
	localparam logic [cfg_offset_w-1:0] cfg_off_pchip_sub   = 8'h2C;
	localparam logic [cfg_offset_w-1:0] cfg_off_cmc_chip    = 8'h30;
	localparam logic [cfg_offset_w-1:0] cfg_off_screen_x    = 8'h34;
	localparam logic [cfg_offset_w-1:0] cfg_off_screen_y    = 8'h38;
	localparam logic [cfg_offset_w-1:0] cfg_off_v2_offset   = 8'h3C;
	localparam logic [cfg_offset_w-1:0] cfg_off_cart_chip   = 8'h40;
	localparam logic [cfg_offset_w-1:0] cfg_off_high_res    = 8'h44;
	localparam logic [cfg_offset_w-1:0] cfg_off_rotation    = 8'h48;
	localparam logic [cfg_offset_w-1:0] cfg_off_v2rom_mask  = 8'h4C;
	localparam logic [cfg_offset_w-1:0] cfg_off_c1_wait     = 8'h54;

	typedef logic [bridge_data_w-1:0] bridge_data_t;

endpackage

// File: rtl/neogeo_cfg_pkg.sv
// neo geo option field widths, reset values, pad layouts,
// rom mask types and protection chip encodings
package neogeo_cfg_pkg;

	// option field widths
	localparam int map_w         = 4;
	localparam int dipsw_w       = 8;
	localparam int system_type_w = 2;
	localparam int memcard_w     = 2;
	localparam int ch_enable_w   = 6;
	localparam int snd_enable_w  = 4;
	localparam int pchip_sub_w   = 3;
	localparam int cmc_w         = 2;
	localparam int cart_chip_w   = 2;
	localparam int v2_w          = 24;
	localparam int c1_wait_w     = 3;
	localparam int screen_pos_w  = 32;

	// non-zero reset values, all dip switches open
	localparam logic [dipsw_w-1:0]       dipsw_reset       = 8'hFF;
	localparam logic [system_type_w-1:0] system_type_reset = 2'd1;
	localparam logic [ch_enable_w-1:0]   ch_enable_reset   = 6'h3F;
	localparam logic [snd_enable_w-1:0]  snd_enable_reset  = 4'hF;

	typedef enum logic [map_w-1:0] {
		layout_pad       = 4'd0,
		layout_neogeo    = 4'd1,
		layout_neogeo_cd = 4'd2
	} pad_layout_t;

	localparam int joy_w = 10;
	typedef logic [15:0] key_t;

	// rom size masks, p2 gets its bank bit on top
	typedef logic [22:0] p2_mask_t;
	typedef logic [18:0] m_mask_t;
	typedef logic [23:0] v1_mask_t;

	// protection chip select codes
	typedef logic [2:0] pchip_t;
	localparam pchip_t pchip_none      = 3'd0;
	localparam pchip_t pchip_main_code = 3'd2;
	localparam pchip_t pchip_sub_bias  = 3'd2;
	localparam logic [pchip_sub_w-1:0] pchip_sub_max = 3'd5;

endpackage

// File: rtl/bridge_decode.sv
// bridge strobe decode into per-target single-cycle strobes
// plus the p2 rom upper bank flag
`timescale 1ns/1ps

module bridge_decode (
	input  logic                                     clk_74a,
	input  logic                                     reset_l_main,
	input  logic [apf_bridge_pkg::bridge_addr_w-1:0] bridge_addr,
	input  logic                                     bridge_wr,
	input  apf_bridge_pkg::bridge_data_t             bridge_wr_data,
	input  logic                                     bridge_rd,
	output logic                                     cfg_wr,
	output logic                                     cfg_rd,
	output logic                                     other_rd,
	output logic [apf_bridge_pkg::cfg_offset_w-1:0]  cfg_offset,
	output apf_bridge_pkg::bridge_data_t             wr_data,
	output logic                                     p2_wr,
	output logic                                     m_wr,
	output logic                                     v1_wr,
	output logic [apf_bridge_pkg::bridge_addr_w-1:0] upload_addr,
	output logic                                     p2_bank_hi
);
	import apf_bridge_pkg::*;

	logic [7:0] addr_top;
	logic       hit_p2;
	logic       hit_m;
	logic       hit_bank1;
	logic       hit_v1;
	logic       hit_cfg;
	logic       bank_flag;
	logic       bank_prev;

	assign addr_top = bridge_addr[31:24];

	// 0x100-0x107 is p2 bank 0 and 0x108 selects bank 1
	assign hit_p2    = (addr_top == region_rom_p) && !bridge_addr[23];
	assign hit_bank1 = (addr_top == region_rom_p) && (bridge_addr[23:20] == 4'h8);
	// m rom sits at 0x10F8 and up
	assign hit_m     = (addr_top == region_rom_p) && (bridge_addr[23:19] == 5'b11111);
	assign hit_v1    = (addr_top == region_rom_v);
	assign hit_cfg   = (addr_top == region_cfg);

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			cfg_wr     <= 1'b0;
			cfg_rd     <= 1'b0;
			other_rd   <= 1'b0;
			p2_wr      <= 1'b0;
			m_wr       <= 1'b0;
			v1_wr      <= 1'b0;
			bank_flag  <= 1'b0;
			bank_prev  <= 1'b0;
			p2_bank_hi <= 1'b0;
		end else begin
			cfg_wr   <= bridge_wr && hit_cfg;
			p2_wr    <= bridge_wr && hit_p2;
			m_wr     <= bridge_wr && hit_m;
			v1_wr    <= bridge_wr && hit_v1;
			cfg_rd   <= bridge_rd && hit_cfg;
			other_rd <= bridge_rd && !hit_cfg;
			if (bridge_wr && hit_bank1) begin
				bank_flag <= 1'b1;
			end else if (bridge_wr && hit_p2) begin
				bank_flag <= 1'b0;
			end
			// bank bit seen before this write goes out with the p2 mask
			if (bridge_wr && hit_p2) begin
				bank_prev <= bank_flag;
			end
			if (p2_wr) begin
				p2_bank_hi <= bank_prev;
			end
		end
	end

	always_ff @(posedge clk_74a) begin
		if (bridge_wr) begin
			wr_data     <= bridge_wr_data;
			upload_addr <= bridge_addr;
		end
		if (bridge_wr || bridge_rd) begin
			cfg_offset <= bridge_addr[cfg_offset_w-1:0];
		end
	end

	a_one_write: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		$onehot0({cfg_wr, p2_wr, m_wr, v1_wr}));

	a_one_read: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		!(cfg_rd && other_rd));

endmodule

// File: rtl/config_regs.sv
// core option register bank with bridge readback
// and protection chip select encoding
`timescale 1ns/1ps

module config_regs (
	input  logic                                       clk_74a,
	input  logic                                       reset_l_main,
	input  logic                                       cfg_wr,
	input  logic                                       cfg_rd,
	input  logic                                       other_rd,
	input  logic [apf_bridge_pkg::cfg_offset_w-1:0]    cfg_offset,
	input  apf_bridge_pkg::bridge_data_t               wr_data,
	output apf_bridge_pkg::bridge_data_t               bridge_rd_data,
	output neogeo_cfg_pkg::pad_layout_t                controller_map_1,
	output neogeo_cfg_pkg::pad_layout_t                controller_map_2,
	output logic [neogeo_cfg_pkg::dipsw_w-1:0]         dipsw,
	output logic [neogeo_cfg_pkg::system_type_w-1:0]   system_type,
	output logic [neogeo_cfg_pkg::memcard_w-1:0]       memory_card_enable,
	output logic                                       video_mode,
	output logic [neogeo_cfg_pkg::ch_enable_w-1:0]     ch_enable,
	output logic [neogeo_cfg_pkg::snd_enable_w-1:0]    snd_enable,
	output logic                                       use_pcm,
	output logic [neogeo_cfg_pkg::cmc_w-1:0]           cmc_chip,
	output logic [neogeo_cfg_pkg::cart_chip_w-1:0]     cart_chip,
	output logic [neogeo_cfg_pkg::screen_pos_w-1:0]    screen_x_pos,
	output logic [neogeo_cfg_pkg::screen_pos_w-1:0]    screen_y_pos,
	output logic [neogeo_cfg_pkg::v2_w-1:0]            v2_offset,
	output logic [neogeo_cfg_pkg::v2_w-1:0]            v2rom_mask,
	output logic                                       high_res,
	output logic                                       screen_rotation,
	output logic [neogeo_cfg_pkg::c1_wait_w-1:0]       c1_wait,
	output neogeo_cfg_pkg::pchip_t                     cart_pchip
);
	import apf_bridge_pkg::*;
	import neogeo_cfg_pkg::*;

	logic                   pchip_main;
	logic [pchip_sub_w-1:0] pchip_sub;

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			controller_map_1   <= layout_pad;
			controller_map_2   <= layout_pad;
			dipsw              <= dipsw_reset;
			system_type        <= system_type_reset;
			memory_card_enable <= '0;
			video_mode         <= 1'b0;
			ch_enable          <= ch_enable_reset;
			snd_enable         <= snd_enable_reset;
			pchip_main         <= 1'b0;
			use_pcm            <= 1'b0;
			pchip_sub          <= '0;
			cmc_chip           <= '0;
			screen_x_pos       <= '0;
			screen_y_pos       <= '0;
			v2_offset          <= '0;
			cart_chip          <= '0;
			high_res           <= 1'b0;
			screen_rotation    <= 1'b0;
			v2rom_mask         <= '0;
			c1_wait            <= '0;
		end else if (cfg_wr) begin
			// low bits only, unknown offsets drop
			case (cfg_offset)
				cfg_off_map_1:       controller_map_1 <= pad_layout_t'(wr_data[map_w-1:0]);
				cfg_off_map_2:       controller_map_2 <= pad_layout_t'(wr_data[map_w-1:0]);
				cfg_off_dipsw:       dipsw <= wr_data[dipsw_w-1:0];
				cfg_off_system_type: system_type <= wr_data[system_type_w-1:0];
				cfg_off_memcard:     memory_card_enable <= wr_data[memcard_w-1:0];
				cfg_off_video_mode:  video_mode <= wr_data[0];
				cfg_off_ch_enable:   ch_enable <= wr_data[ch_enable_w-1:0];
				cfg_off_snd_enable:  snd_enable <= wr_data[snd_enable_w-1:0];
				cfg_off_pchip_main:  pchip_main <= wr_data[0];
				cfg_off_use_pcm:     use_pcm <= wr_data[0];
				cfg_off_pchip_sub:   pchip_sub <= wr_data[pchip_sub_w-1:0];
				cfg_off_cmc_chip:    cmc_chip <= wr_data[cmc_w-1:0];
				cfg_off_screen_x:    screen_x_pos <= wr_data[screen_pos_w-1:0];
				cfg_off_screen_y:    screen_y_pos <= wr_data[screen_pos_w-1:0];
				cfg_off_v2_offset:   v2_offset <= wr_data[v2_w-1:0];
				cfg_off_cart_chip:   cart_chip <= wr_data[cart_chip_w-1:0];
				cfg_off_high_res:    high_res <= wr_data[0];
				cfg_off_rotation:    screen_rotation <= wr_data[0];
				cfg_off_v2rom_mask:  v2rom_mask <= wr_data[v2_w-1:0];
				cfg_off_c1_wait:     c1_wait <= wr_data[c1_wait_w-1:0];
				default: ;
			endcase
		end
	end

	// read data holds until the next read
	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			bridge_rd_data <= '0;
		end else if (other_rd) begin
			bridge_rd_data <= '0;
		end else if (cfg_rd) begin
			case (cfg_offset)
				cfg_off_map_1:       bridge_rd_data <= bridge_data_t'(controller_map_1);
				cfg_off_map_2:       bridge_rd_data <= bridge_data_t'(controller_map_2);
				cfg_off_dipsw:       bridge_rd_data <= bridge_data_t'(dipsw);
				cfg_off_system_type: bridge_rd_data <= bridge_data_t'(system_type);
				cfg_off_memcard:     bridge_rd_data <= bridge_data_t'(memory_card_enable);
				cfg_off_video_mode:  bridge_rd_data <= bridge_data_t'(video_mode);
				cfg_off_ch_enable:   bridge_rd_data <= bridge_data_t'(ch_enable);
				cfg_off_snd_enable:  bridge_rd_data <= bridge_data_t'(snd_enable);
				cfg_off_pchip_main:  bridge_rd_data <= bridge_data_t'(pchip_main);
				cfg_off_use_pcm:     bridge_rd_data <= bridge_data_t'(use_pcm);
				cfg_off_pchip_sub:   bridge_rd_data <= bridge_data_t'(pchip_sub);
				cfg_off_cmc_chip:    bridge_rd_data <= bridge_data_t'(cmc_chip);
				cfg_off_screen_x:    bridge_rd_data <= bridge_data_t'(screen_x_pos);
				cfg_off_screen_y:    bridge_rd_data <= bridge_data_t'(screen_y_pos);
				cfg_off_v2_offset:   bridge_rd_data <= bridge_data_t'(v2_offset);
				cfg_off_cart_chip:   bridge_rd_data <= bridge_data_t'(cart_chip);
				cfg_off_high_res:    bridge_rd_data <= bridge_data_t'(high_res);
				cfg_off_rotation:    bridge_rd_data <= bridge_data_t'(screen_rotation);
				cfg_off_v2rom_mask:  bridge_rd_data <= bridge_data_t'(v2rom_mask);
				cfg_off_c1_wait:     bridge_rd_data <= bridge_data_t'(c1_wait);
				default:             bridge_rd_data <= '0;
			endcase
		end
	end

	// main chip wins, sub chips 1..5 map to codes 3..7
	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			cart_pchip <= pchip_none;
		end else if (pchip_main) begin
			cart_pchip <= pchip_main_code;
		end else if ((pchip_sub != '0) && (pchip_sub <= pchip_sub_max)) begin
			cart_pchip <= pchip_t'(pchip_sub + pchip_sub_bias);
		end else begin
			cart_pchip <= pchip_none;
		end
	end

endmodule

// File: rtl/rom_mask_tracker.sv
// rom size mask taken from upload write addresses
`timescale 1ns/1ps

module rom_mask_tracker #(
	parameter type mask_t = logic [15:0]
) (
	input  logic                                     clk_74a,
	input  logic                                     reset_l_main,
	input  logic                                     upload_wr,
	input  logic [apf_bridge_pkg::bridge_addr_w-1:0] upload_addr,
	output mask_t                                    mask
);
	localparam int mask_w = $bits(mask_t);

	mask_t smeared;

	// every bit at or below the top set address bit goes high
	always_comb begin
		smeared[mask_w-1] = upload_addr[mask_w-1];
		for (int i = mask_w - 2; i >= 0; i--) begin
			smeared[i] = smeared[i+1] | upload_addr[i];
		end
	end

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			mask <= '0;
		end else if (upload_wr) begin
			mask <= smeared;
		end
	end

	// mask stays a solid run of ones from bit 0
	a_mask_solid: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		(mask & mask_t'(mask + 1'b1)) == '0);

endmodule

// File: rtl/joypad_remap.sv
// pad key word to neo geo joystick word, per button layout
`timescale 1ns/1ps

module joypad_remap (
	input  logic                              clk_74a,
	input  logic                              reset_l_main,
	input  neogeo_cfg_pkg::key_t              key,
	input  neogeo_cfg_pkg::pad_layout_t       layout,
	output logic [neogeo_cfg_pkg::joy_w-1:0]  joystick
);
	import neogeo_cfg_pkg::*;

	logic [1:0] sys_keys;
	logic [3:0] dir_keys;
	logic [3:0] face_keys;

	// select, start
	assign sys_keys = {key[14], key[15]};
	// up, down, left, right
	assign dir_keys = {key[0], key[1], key[2], key[3]};

	// key bits 4..7 are a, b, x, y
	always_comb begin
		case (layout)
			layout_neogeo:    face_keys = {key[4], key[6], key[5], key[7]};
			layout_neogeo_cd: face_keys = {key[6], key[7], key[4], key[5]};
			default:          face_keys = key[7:4];
		endcase
	end

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			joystick <= '0;
		end else begin
			joystick <= {sys_keys, face_keys, dir_keys};
		end
	end

endmodule

// File: rtl/apf_io_top.sv
// i/o hand-off top: bridge decode, option bank,
// rom mask trackers and pad remappers
`timescale 1ns/1ps

module apf_io_top (
	input  logic                                       clk_74a,
	input  logic                                       reset_l_main,
	input  logic [apf_bridge_pkg::bridge_addr_w-1:0]   bridge_addr,
	input  logic                                       bridge_wr,
	input  apf_bridge_pkg::bridge_data_t               bridge_wr_data,
	input  logic                                       bridge_rd,
	output apf_bridge_pkg::bridge_data_t               bridge_rd_data,
	input  neogeo_cfg_pkg::key_t                       cont1_key,
	input  neogeo_cfg_pkg::key_t                       cont2_key,
	output logic [neogeo_cfg_pkg::dipsw_w-1:0]         dipsw,
	output logic [neogeo_cfg_pkg::system_type_w-1:0]   system_type,
	output logic [neogeo_cfg_pkg::memcard_w-1:0]       memory_card_enable,
	output logic                                       video_mode,
	output logic [neogeo_cfg_pkg::ch_enable_w-1:0]     ch_enable,
	output logic [neogeo_cfg_pkg::snd_enable_w-1:0]    snd_enable,
	output logic                                       use_pcm,
	output logic [neogeo_cfg_pkg::cmc_w-1:0]           cmc_chip,
	output logic [neogeo_cfg_pkg::cart_chip_w-1:0]     cart_chip,
	output logic [neogeo_cfg_pkg::screen_pos_w-1:0]    screen_x_pos,
	output logic [neogeo_cfg_pkg::screen_pos_w-1:0]    screen_y_pos,
	output logic [neogeo_cfg_pkg::v2_w-1:0]            v2_offset,
	output logic [neogeo_cfg_pkg::v2_w-1:0]            v2rom_mask,
	output logic                                       high_res,
	output logic                                       screen_rotation,
	output logic [neogeo_cfg_pkg::c1_wait_w-1:0]       c1_wait,
	output neogeo_cfg_pkg::pchip_t                     cart_pchip,
	output logic [$bits(neogeo_cfg_pkg::p2_mask_t):0]  p2rom_mask,
	output neogeo_cfg_pkg::m_mask_t                    mrom_mask,
	output neogeo_cfg_pkg::v1_mask_t                   v1rom_mask,
	output logic [neogeo_cfg_pkg::joy_w-1:0]           joystick_0,
	output logic [neogeo_cfg_pkg::joy_w-1:0]           joystick_1
);
	import apf_bridge_pkg::*;
	import neogeo_cfg_pkg::*;

	logic                     cfg_wr;
	logic                     cfg_rd;
	logic                     other_rd;
	logic [cfg_offset_w-1:0]  cfg_offset;
	bridge_data_t             wr_data;
	logic                     p2_wr;
	logic                     m_wr;
	logic                     v1_wr;
	logic [bridge_addr_w-1:0] upload_addr;
	logic                     p2_bank_hi;
	p2_mask_t                 p2_mask_lo;
	pad_layout_t              controller_map_1;
	pad_layout_t              controller_map_2;

	bridge_decode u_decode (.*);

	config_regs u_regs (.*);

	rom_mask_tracker #(.mask_t(p2_mask_t)) u_p2_mask (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.upload_wr    (p2_wr),
		.upload_addr  (upload_addr),
		.mask         (p2_mask_lo)
	);

	rom_mask_tracker #(.mask_t(m_mask_t)) u_m_mask (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.upload_wr    (m_wr),
		.upload_addr  (upload_addr),
		.mask         (mrom_mask)
	);

	rom_mask_tracker #(.mask_t(v1_mask_t)) u_v1_mask (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.upload_wr    (v1_wr),
		.upload_addr  (upload_addr),
		.mask         (v1rom_mask)
	);

	// upper bank bit sits above the 23-bit p2 mask
	assign p2rom_mask = {p2_bank_hi, p2_mask_lo};

	joypad_remap u_pad_1 (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.key          (cont1_key),
		.layout       (controller_map_1),
		.joystick     (joystick_0)
	);

	joypad_remap u_pad_2 (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.key          (cont2_key),
		.layout       (controller_map_2),
		.joystick     (joystick_1)
	);

endmodule

// File: tests/tb_apf_io.sv
// testbench for the i/o hand-off top with option bank and readback,
// protection chip encoding, rom size masks and pad remap
`timescale 1ns/1ps

module tb_apf_io;
	import apf_bridge_pkg::*;
	import neogeo_cfg_pkg::*;

	localparam int clk_period   = 4;
	localparam int reset_cycles = 5;
	localparam int op_cycles    = 3;
	localparam int write_rounds = 3;
	localparam int n_known      = 20;
	localparam int n_unknown    = 6;
	localparam int n_other      = 4;
	localparam int mask_rounds  = 4;
	localparam int key_steps    = 16;
	localparam int test_cycles  = reset_cycles + 8
		+ write_rounds * n_known * 2 * op_cycles
		+ (n_unknown * 2 + n_known) * op_cycles
		+ (1 + n_other * 2) * op_cycles
		+ 16 * (2 * op_cycles + 2)
		+ mask_rounds * 7 * op_cycles
		+ 4 * (2 * op_cycles + key_steps + 2);
	localparam int watchdog_cycles = test_cycles * 2 + 200;

	// host pad key word bit positions
	localparam int key_up     = 0;
	localparam int key_down   = 1;
	localparam int key_left   = 2;
	localparam int key_right  = 3;
	localparam int key_a      = 4;
	localparam int key_b      = 5;
	localparam int key_x      = 6;
	localparam int key_y      = 7;
	localparam int key_select = 14;
	localparam int key_start  = 15;

	// error groups
	localparam int grp_opt  = 0;
	localparam int grp_rd   = 1;
	localparam int grp_mask = 2;
	localparam int grp_joy  = 3;

	logic                     clk_74a;
	logic                     reset_l_main;
	logic [bridge_addr_w-1:0] bridge_addr;
	logic                     bridge_wr;
	bridge_data_t             bridge_wr_data;
	logic                     bridge_rd;
	bridge_data_t             bridge_rd_data;
	key_t                     cont1_key;
	key_t                     cont2_key;
	logic [dipsw_w-1:0]       dipsw;
	logic [system_type_w-1:0] system_type;
	logic [memcard_w-1:0]     memory_card_enable;
	logic                     video_mode;
	logic [ch_enable_w-1:0]   ch_enable;
	logic [snd_enable_w-1:0]  snd_enable;
	logic                     use_pcm;
	logic [cmc_w-1:0]         cmc_chip;
	logic [cart_chip_w-1:0]   cart_chip;
	logic [screen_pos_w-1:0]  screen_x_pos;
	logic [screen_pos_w-1:0]  screen_y_pos;
	logic [v2_w-1:0]          v2_offset;
	logic [v2_w-1:0]          v2rom_mask;
	logic                     high_res;
	logic                     screen_rotation;
	logic [c1_wait_w-1:0]     c1_wait;
	pchip_t                   cart_pchip;
	logic [23:0]              p2rom_mask;
	m_mask_t                  mrom_mask;
	v1_mask_t                 v1rom_mask;
	logic [joy_w-1:0]         joystick_0;
	logic [joy_w-1:0]         joystick_1;

	// expected state updated at the edge where the dut stores it
	logic [31:0] exp_reg [256];
	logic [31:0] exp_rd;
	logic [23:0] exp_p2;
	logic [18:0] exp_m;
	logic [23:0] exp_v1;
	logic        bank_flag;
	logic        reset_done;
	int          err_count [4];

	logic [7:0] known_offs [n_known] = '{
		cfg_off_map_1, cfg_off_map_2, cfg_off_dipsw, cfg_off_system_type,
		cfg_off_memcard, cfg_off_video_mode, cfg_off_ch_enable, cfg_off_snd_enable,
		cfg_off_pchip_main, cfg_off_use_pcm, cfg_off_pchip_sub, cfg_off_cmc_chip,
		cfg_off_screen_x, cfg_off_screen_y, cfg_off_v2_offset, cfg_off_cart_chip,
		cfg_off_high_res, cfg_off_rotation, cfg_off_v2rom_mask, cfg_off_c1_wait
	};
	logic [7:0]  unknown_offs [n_unknown] = '{8'h14, 8'h50, 8'h58, 8'h02, 8'h0D, 8'hFC};
	logic [31:0] other_addrs [n_other] = '{32'h3000_0008, 32'h1000_0008,
		32'h2000_0008, 32'hF100_0008};
	// 9 is not a defined layout
	logic [3:0]  pad_layouts [4] = '{4'd0, 4'd1, 4'd2, 4'd9};

	apf_io_top dut0 (.*);

	initial begin
		clk_74a = 1'b0;
		forever #(clk_period / 2) clk_74a = ~clk_74a;
	end

	function automatic int field_width(input logic [7:0] off);
		case (off)
			cfg_off_map_1, cfg_off_map_2:         return map_w;
			cfg_off_dipsw:                        return dipsw_w;
			cfg_off_system_type:                  return system_type_w;
			cfg_off_memcard:                      return memcard_w;
			cfg_off_ch_enable:                    return ch_enable_w;
			cfg_off_snd_enable:                   return snd_enable_w;
			cfg_off_pchip_sub:                    return pchip_sub_w;
			cfg_off_cmc_chip:                     return cmc_w;
			cfg_off_cart_chip:                    return cart_chip_w;
			cfg_off_screen_x, cfg_off_screen_y:   return screen_pos_w;
			cfg_off_v2_offset, cfg_off_v2rom_mask: return v2_w;
			cfg_off_c1_wait:                      return c1_wait_w;
			cfg_off_video_mode, cfg_off_pchip_main, cfg_off_use_pcm,
			cfg_off_high_res, cfg_off_rotation:   return 1;
			default:                              return 0;
		endcase
	endfunction

	function automatic logic [31:0] width_mask(input int w);
		if (w >= 32) begin
			return '1;
		end
		return (32'd1 << w) - 32'd1;
	endfunction

	// every bit at or below the top set bit of the low w bits
	function automatic logic [31:0] smear(input logic [31:0] addr, input int w);
		logic [31:0] r;
		logic        seen;
		r = '0;
		seen = 1'b0;
		for (int i = w - 1; i >= 0; i--) begin
			seen = seen | addr[i];
			r[i] = seen;
		end
		return r;
	endfunction

	function automatic pchip_t ref_pchip(input logic main, input logic [2:0] sub);
		if (main) begin
			return 3'd2;
		end else if (sub >= 3'd1 && sub <= 3'd5) begin
			return sub + 3'd2;
		end
		return 3'd0;
	endfunction

	function automatic logic [joy_w-1:0] ref_joystick(input key_t key,
		input logic [3:0] layout);
		logic [3:0] face;
		case (layout)
			layout_neogeo:    face = {key[key_a], key[key_x], key[key_b], key[key_y]};
			layout_neogeo_cd: face = {key[key_x], key[key_y], key[key_a], key[key_b]};
			default:          face = {key[key_y], key[key_x], key[key_b], key[key_a]};
		endcase
		return {key[key_select], key[key_start], face,
			key[key_up], key[key_down], key[key_left], key[key_right]};
	endfunction

	function automatic logic [31:0] ref_read(input logic [31:0] addr);
		if (addr[31:24] == region_cfg && field_width(addr[7:0]) > 0) begin
			return exp_reg[addr[7:0]];
		end
		return '0;
	endfunction

	function automatic logic [31:0] rand_bits(input int w);
		return $urandom() & width_mask(int'($urandom_range(w, 1)));
	endfunction

	// bridge write decode as seen by the rest of the core
	task automatic model_write(input logic [31:0] addr, input logic [31:0] data);
		logic [7:0]  off;
		logic [31:0] s;
		off = addr[7:0];
		case (addr[31:24])
			region_cfg: begin
				if (field_width(off) > 0) begin
					exp_reg[off] = data & width_mask(field_width(off));
				end
			end
			region_rom_p: begin
				if (!addr[23]) begin
					s = smear(addr, 23);
					exp_p2 = {bank_flag, s[22:0]};
					bank_flag = 1'b0;
				end else if (addr[23:20] == 4'h8) begin
					bank_flag = 1'b1;
				end else if (addr[23:19] == 5'b11111) begin
					s = smear(addr, 19);
					exp_m = s[18:0];
				end
			end
			region_rom_v: begin
				s = smear(addr, 24);
				exp_v1 = s[23:0];
			end
			default: ;
		endcase
	endtask

	task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk_74a);
		bridge_addr <= addr;
		bridge_wr_data <= data;
		bridge_wr <= 1'b1;
		@(posedge clk_74a);
		bridge_wr <= 1'b0;
		@(posedge clk_74a);
		model_write(addr, data);
	endtask

	task automatic bridge_read(input logic [31:0] addr);
		@(posedge clk_74a);
		bridge_addr <= addr;
		bridge_rd <= 1'b1;
		@(posedge clk_74a);
		bridge_rd <= 1'b0;
		@(posedge clk_74a);
		exp_rd = ref_read(addr);
	endtask

	task automatic compare_word(input string name, input logic [31:0] got,
		input logic [31:0] expected, input int group);
		assert (got === expected) else begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
			err_count[group]++;
		end
	endtask

	task automatic check_options();
		compare_word("dipsw", 32'(dipsw), exp_reg[cfg_off_dipsw], grp_opt);
		compare_word("system_type", 32'(system_type), exp_reg[cfg_off_system_type], grp_opt);
		compare_word("memory_card_enable", 32'(memory_card_enable),
			exp_reg[cfg_off_memcard], grp_opt);
		compare_word("video_mode", 32'(video_mode), exp_reg[cfg_off_video_mode], grp_opt);
		compare_word("ch_enable", 32'(ch_enable), exp_reg[cfg_off_ch_enable], grp_opt);
		compare_word("snd_enable", 32'(snd_enable), exp_reg[cfg_off_snd_enable], grp_opt);
		compare_word("use_pcm", 32'(use_pcm), exp_reg[cfg_off_use_pcm], grp_opt);
		compare_word("cmc_chip", 32'(cmc_chip), exp_reg[cfg_off_cmc_chip], grp_opt);
		compare_word("cart_chip", 32'(cart_chip), exp_reg[cfg_off_cart_chip], grp_opt);
		compare_word("screen_x_pos", screen_x_pos, exp_reg[cfg_off_screen_x], grp_opt);
		compare_word("screen_y_pos", screen_y_pos, exp_reg[cfg_off_screen_y], grp_opt);
		compare_word("v2_offset", 32'(v2_offset), exp_reg[cfg_off_v2_offset], grp_opt);
		compare_word("v2rom_mask", 32'(v2rom_mask), exp_reg[cfg_off_v2rom_mask], grp_opt);
		compare_word("high_res", 32'(high_res), exp_reg[cfg_off_high_res], grp_opt);
		compare_word("screen_rotation", 32'(screen_rotation),
			exp_reg[cfg_off_rotation], grp_opt);
		compare_word("c1_wait", 32'(c1_wait), exp_reg[cfg_off_c1_wait], grp_opt);
		compare_word("bridge_rd_data", bridge_rd_data, exp_rd, grp_rd);
		compare_word("p2rom_mask", 32'(p2rom_mask), 32'(exp_p2), grp_mask);
		compare_word("mrom_mask", 32'(mrom_mask), 32'(exp_m), grp_mask);
		compare_word("v1rom_mask", 32'(v1rom_mask), 32'(exp_v1), grp_mask);
	endtask

	// checks every falling edge; pchip and joysticks lag by one cycle
	initial begin : compare_outputs
		pchip_t           pchip_due;
		logic [joy_w-1:0] joy0_due;
		logic [joy_w-1:0] joy1_due;
		pchip_due = '0;
		joy0_due = '0;
		joy1_due = '0;
		wait (reset_done);
		forever begin
			@(negedge clk_74a);
			check_options();
			compare_word("cart_pchip", 32'(cart_pchip), 32'(pchip_due), grp_opt);
			compare_word("joystick_0", 32'(joystick_0), 32'(joy0_due), grp_joy);
			compare_word("joystick_1", 32'(joystick_1), 32'(joy1_due), grp_joy);
			pchip_due = ref_pchip(exp_reg[cfg_off_pchip_main][0],
				exp_reg[cfg_off_pchip_sub][2:0]);
			joy0_due = ref_joystick(cont1_key, exp_reg[cfg_off_map_1][3:0]);
			joy1_due = ref_joystick(cont2_key, exp_reg[cfg_off_map_2][3:0]);
		end
	end

	initial begin : watchdog
		#(watchdog_cycles * clk_period);
		$display("Timeout: test did not finish within %0d cycles", watchdog_cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin : stimulus
		logic [31:0] bits;
		int          total;
		void'($urandom(32'h2cc9));
		reset_l_main <= 1'b0;
		bridge_addr <= '0;
		bridge_wr <= 1'b0;
		bridge_wr_data <= '0;
		bridge_rd <= 1'b0;
		cont1_key <= '0;
		cont2_key <= '0;
		reset_done = 1'b0;
		for (int i = 0; i < 256; i++) begin
			exp_reg[i] = '0;
		end
		exp_reg[cfg_off_dipsw] = 32'(dipsw_reset);
		exp_reg[cfg_off_system_type] = 32'(system_type_reset);
		exp_reg[cfg_off_ch_enable] = 32'(ch_enable_reset);
		exp_reg[cfg_off_snd_enable] = 32'(snd_enable_reset);
		exp_rd = '0;
		exp_p2 = '0;
		exp_m = '0;
		exp_v1 = '0;
		bank_flag = 1'b0;
		for (int g = 0; g < 4; g++) begin
			err_count[g] = 0;
		end
		repeat (reset_cycles) @(posedge clk_74a);
		reset_l_main <= 1'b1;
		reset_done = 1'b1;
		repeat (3) @(posedge clk_74a);

		// random writes and readback with the upper window bits ignored
		for (int r = 0; r < write_rounds; r++) begin
			for (int i = 0; i < n_known; i++) begin
				bits = {8'hF0, 16'($urandom()), known_offs[i]};
				bridge_write(bits, $urandom());
				bridge_read(bits);
			end
		end
		for (int i = 0; i < n_unknown; i++) begin
			bridge_write({24'hF00000, unknown_offs[i]}, $urandom());
			bridge_read({24'hF00000, unknown_offs[i]});
		end
		for (int i = 0; i < n_known; i++) begin
			bridge_read({24'hF00000, known_offs[i]});
		end
		bridge_write({24'hF00000, cfg_off_dipsw}, 32'h0000_00A5);
		for (int i = 0; i < n_other; i++) begin
			bridge_read({24'hF00000, cfg_off_dipsw});
			bridge_read(other_addrs[i]);
		end

		// all protection chip pairs
		for (int m = 0; m < 2; m++) begin
			for (int s = 0; s < 8; s++) begin
				bridge_write({24'hF00000, cfg_off_pchip_main}, {31'($urandom()), 1'(m)});
				bridge_write({24'hF00000, cfg_off_pchip_sub}, {29'($urandom()), 3'(s)});
				repeat (2) @(posedge clk_74a);
			end
		end

		// rom uploads, p2 bank bit and writes that hit no tracker
		for (int r = 0; r < mask_rounds; r++) begin
			bits = rand_bits(23);
			bridge_write({8'h10, 1'b0, bits[22:0]}, $urandom());
			bridge_write({8'h10, 4'h8, bits[19:0]}, $urandom());
			bits = rand_bits(23);
			bridge_write({8'h10, 1'b0, bits[22:0]}, $urandom());
			bits = rand_bits(19);
			bridge_write({8'h10, 5'b11111, bits[18:0]}, $urandom());
			bits = rand_bits(24);
			bridge_write({8'h20, bits[23:0]}, $urandom());
			bridge_write({8'h10, 5'b11110, bits[18:0]}, $urandom());
			bridge_write({8'h30, bits[23:0]}, $urandom());
		end

		// pad layouts with player 2 one layout ahead
		for (int l = 0; l < 4; l++) begin
			bridge_write({24'hF00000, cfg_off_map_1}, {28'($urandom()), pad_layouts[l]});
			bridge_write({24'hF00000, cfg_off_map_2},
				{28'($urandom()), pad_layouts[(l + 1) % 4]});
			for (int k = 0; k < key_steps; k++) begin
				@(posedge clk_74a);
				cont1_key <= 16'($urandom());
				cont2_key <= 16'($urandom());
			end
			repeat (2) @(posedge clk_74a);
		end

		repeat (4) @(posedge clk_74a);
		total = err_count[grp_opt] + err_count[grp_rd]
			+ err_count[grp_mask] + err_count[grp_joy];
		$display("Errors: options %0d, readback %0d, masks %0d, joysticks %0d, total %0d",
			err_count[grp_opt], err_count[grp_rd], err_count[grp_mask],
			err_count[grp_joy], total);
		if (total == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: vlog.f
rtl/apf_bridge_pkg.sv
rtl/neogeo_cfg_pkg.sv
rtl/bridge_decode.sv
rtl/config_regs.sv
rtl/rom_mask_tracker.sv
rtl/joypad_remap.sv
rtl/apf_io_top.sv
tests/tb_apf_io.sv

// File: Makefile
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
TOP        := tb_apf_io
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
PASS_MSG   := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
